/* list.f */
uart_regs_pkg.sv
dii_pkg.sv
uart_axi_bridge.sv
uart_16550_regs.sv
uart_dii_emul.sv
uart_emul_top.sv
uart_emul_chk.sv
tb_uart_emul.sv

/* tb_uart_emul.sv */
/* Testbench for the emulated UART. Drives AXI-lite accesses and debug
   packets, a register model predicts reads and outgoing flits */

`timescale 1ns/1ps

module tb_uart_emul
   import uart_regs_pkg::*, dii_pkg::*;
();

   localparam logic [DII_ID_W-1:0] NODE_ID = 10'h2a5;
   localparam int N_CHARS  = 8;
   localparam int N_ACCESS = 40;
   localparam int N_PKTS   = N_CHARS + 3;
   localparam int LIMIT_CYCLES = N_ACCESS * 20 + N_PKTS * 60 + 100; // Per access/packet budget

   logic clk, rst;
   logic [2:0] ar_addr, aw_addr;
   logic [7:0] r_data, w_data;
   logic [1:0] r_resp, b_resp;
   logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
   logic w_valid, w_ready, b_valid, b_ready, debug_out_ready, debug_in_ready;
   dii_flit_t debug_out, debug_in;

   integer seed = 32'h14da;
   int errors, err_mark, n_tests, n_pass, resp_seq;
   dii_flit_t exp_q[$];
   dii_flit_t got_q[$];
   logic [7:0] m_scr, m_ier, m_lcr, m_dll, m_dlm, m_rbr; // Register model
   logic m_dr;

   uart_emul_top dut_i (.id(NODE_ID), .*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [7:0] ref_read(input logic [2:0] a);
      logic dlab;
      dlab = m_lcr[LCR_DLAB];
      case (a)
         REG_RBR_THR: return dlab ? m_dll : m_rbr;
         REG_IER:     return dlab ? m_dlm : m_ier;
         REG_IIR_FCR: return IIR_NO_INT;
         REG_LCR:     return m_lcr;
         REG_LSR:     return {1'b0, 2'b11, 4'b0, m_dr}; // Read only with tx idle
         REG_SCR:     return m_scr;
         default:     return 8'h00;
      endcase
   endfunction

   function automatic dii_flit_t ref_flit(input logic [7:0] ch, input int idx);
      dii_flit_t f;
      f.valid = 1'b1;
      f.last  = (idx == PKT_LEN - 1);
      case (idx)
         0:       f.data = 16'(HOST_ID);
         1:       f.data = 16'(NODE_ID);
         2:       f.data = {TYPE_EVENT, SUBTYPE_CHAR, 10'd0};
         default: f.data = {8'd0, ch};
      endcase
      return f;
   endfunction

   task automatic check_val(input string name, input logic [17:0] got, input logic [17:0] exp);
      assert (got === exp)
      else begin
         errors++;
         $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic reg_write(input logic [2:0] a, input logic [7:0] d, output int seq);
      if (a == REG_RBR_THR && !m_lcr[LCR_DLAB]) begin
         for (int i = 0; i < PKT_LEN; i++) exp_q.push_back(ref_flit(d, i));
      end
      case (a)
         REG_RBR_THR: if (m_lcr[LCR_DLAB]) m_dll = d;
         REG_IER:     if (m_lcr[LCR_DLAB]) m_dlm = d; else m_ier = d;
         REG_LCR:     m_lcr = d;
         REG_SCR:     m_scr = d;
         default:     ;
      endcase
      @(posedge clk);
      aw_addr  <= a;
      w_data   <= d;
      aw_valid <= 1'b1;
      w_valid  <= 1'b1;
      do @(negedge clk); while (!(aw_ready && w_ready));
      @(posedge clk);
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      do @(negedge clk); while (!b_valid); // b_ready tied high
      seq = resp_seq;
      resp_seq++;
      check_val("b_resp", b_resp, AXI_OKAY);
   endtask

   task automatic reg_read(input logic [2:0] a, input string name, output int seq);
      @(posedge clk);
      ar_addr  <= a;
      ar_valid <= 1'b1;
      do @(negedge clk); while (!ar_ready);
      @(posedge clk);
      ar_valid <= 1'b0;
      do @(negedge clk); while (!r_valid);
      seq = resp_seq;
      resp_seq++;
      check_val("r_resp", r_resp, AXI_OKAY);
      check_val(name, r_data, ref_read(a)); // Model read after a concurrent write
      if (a == REG_RBR_THR && !m_lcr[LCR_DLAB]) m_dr = 1'b0;
   endtask

   // Host to UART packet, dest is the UART node
   task automatic send_packet(input logic [3:0] subtype, input logic [7:0] ch);
      logic [15:0] words [PKT_LEN];
      words[0] = 16'(NODE_ID);
      words[1] = 16'(HOST_ID);
      words[2] = {TYPE_EVENT, subtype, 10'd0};
      words[3] = {8'd0, ch};
      for (int i = 0; i < PKT_LEN; i++) begin
         @(posedge clk);
         debug_in <= '{valid: 1'b1, last: (i == PKT_LEN - 1), data: words[i]};
         do @(negedge clk); while (!debug_in_ready);
      end
      @(posedge clk);
      debug_in <= '0;
      if (subtype == SUBTYPE_CHAR) begin
         m_dr  = 1'b1;
         m_rbr = ch;
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (errors == err_mark) begin
         n_pass++;
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         $display("test %0d %s: FAILED with %0d errors", n_tests, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // Debug host, random back-pressure on debug_out
   initial begin
      debug_out_ready <= 1'b0;
      forever begin
         @(posedge clk);
         debug_out_ready <= ($random(seed) & 3) != 0;
      end
   end

   always @(negedge clk) begin
      if (!rst && debug_out.valid && debug_out_ready) got_q.push_back(debug_out);
   end

   always @(posedge clk) begin : compare_flits
      dii_flit_t got;
      while (got_q.size() > 0) begin
         got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected flit %0h on debug_out at %0t", got, $time);
         end else begin
            check_val("debug_out", got, exp_q.pop_front());
         end
      end
   end

   initial begin
      #(LIMIT_CYCLES * 8);
      $display("timeout: tests did not finish within %0d cycles", LIMIT_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      int s0;
      int s1;
      rst <= 1'b1;
      ar_addr <= '0;
      ar_valid <= 1'b0;
      r_ready <= 1'b1;
      aw_addr <= '0;
      aw_valid <= 1'b0;
      w_data <= '0;
      w_valid <= 1'b0;
      b_ready <= 1'b1;
      debug_in <= '0;
      {m_scr, m_ier, m_lcr, m_dll, m_dlm, m_rbr} = '0;
      m_dr = 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      reg_write(REG_SCR, 8'ha5, s0);
      reg_write(REG_IER, 8'h0f, s0);
      reg_write(REG_LCR, 8'h1b, s0);
      reg_read(REG_SCR, "scr", s0);
      reg_read(REG_IER, "ier", s0);
      reg_read(REG_LCR, "lcr", s0);
      reg_read(REG_IIR_FCR, "iir", s0);
      end_test("register readback");

      reg_read(REG_LSR, "lsr", s0);
      send_packet(SUBTYPE_CHAR, 8'h5a);
      reg_read(REG_LSR, "lsr", s0);
      reg_read(REG_RBR_THR, "rbr", s0);
      reg_read(REG_LSR, "lsr", s0);
      send_packet(4'h3, 8'hc3); // Not a character, dropped
      reg_read(REG_LSR, "lsr", s0);
      end_test("receive path");

      reg_write(REG_LCR, 8'h9b, s0);
      reg_write(REG_RBR_THR, 8'h36, s0);
      reg_write(REG_IER, 8'h01, s0);
      reg_read(REG_RBR_THR, "dll", s0);
      reg_read(REG_IER, "dlm", s0);
      reg_write(REG_LCR, 8'h1b, s0);
      reg_read(REG_RBR_THR, "rbr", s0);
      end_test("divisor latch");

      for (int i = 0; i < N_CHARS; i++) reg_write(REG_RBR_THR, 8'($random(seed)), s0);
      wait_drained();
      end_test("transmit packets");

      reg_read(REG_LSR, "lsr", s0);
      reg_write(REG_RBR_THR, 8'h0d, s0);
      wait_drained();
      reg_read(REG_LSR, "lsr", s0);
      end_test("thre after drain");

      fork
         reg_write(REG_SCR, 8'h3c, s0);
         reg_read(REG_SCR, "scr", s1);
      join
      assert (s0 < s1)
      else begin
         errors++;
         $display("read finished before the write issued in the same cycle at %0t", $time);
      end
      end_test("write priority");

      $display("tests: %0d, passed: %0d, errors: %0d", n_tests, n_pass, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* uart_emul_chk.sv */
/* Concurrent checks on the register-bus handshake, the AXI response
   channels and debug_out stability, bound into the UART top level */

`timescale 1ns/1ps

module uart_emul_chk
   import uart_regs_pkg::*, dii_pkg::*;
(
   input logic          clk,
   input logic          rst,
   input logic          bus_req,
   input uart_bus_req_t bus,
   input logic          bus_ack,
   input logic          r_valid,
   input logic          b_valid,
   input dii_flit_t     debug_out,
   input logic          debug_out_ready
);

   req_held: assert property (@(posedge clk) disable iff (rst)
      bus_req && !bus_ack |=> bus_req)
      else $error("register req dropped before ack");

   bus_stable: assert property (@(posedge clk) disable iff (rst)
      bus_req |=> !bus_req || $stable(bus))
      else $error("register request changed while req high");

   // Four-phase, ack follows req down
   ack_held: assert property (@(posedge clk) disable iff (rst)
      bus_ack && bus_req |=> bus_ack)
      else $error("ack fell while req still high");

   resp_excl: assert property (@(posedge clk) disable iff (rst)
      !(r_valid && b_valid))
      else $error("r_valid and b_valid high together");

   flit_stall: assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> $stable(debug_out))
      else $error("debug_out flit changed under stall");

endmodule

bind uart_emul_top uart_emul_chk chk_i (
   .clk(clk), .rst(rst), .bus_req(bus_req), .bus(bus), .bus_ack(bus_ack),
   .r_valid(r_valid), .b_valid(b_valid), .debug_out(debug_out),
   .debug_out_ready(debug_out_ready)
);

/* uart_emul_top.sv */
/* Emulated 16550 UART. AXI-lite register access on one side, debug
   interconnect character packets on the other */

`timescale 1ns/1ps

module uart_emul_top
   import uart_regs_pkg::*, dii_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [DII_ID_W-1:0]   id,

   input  logic [REG_ADDR_W-1:0] ar_addr,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   output logic [1:0]            r_resp,
   output logic [REG_DATA_W-1:0] r_data,
   output logic                  r_valid,
   input  logic                  r_ready,
   input  logic [REG_ADDR_W-1:0] aw_addr,
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  logic [REG_DATA_W-1:0] w_data,
   input  logic                  w_valid,
   output logic                  w_ready,
   output logic [1:0]            b_resp,
   output logic                  b_valid,
   input  logic                  b_ready,

   output dii_flit_t             debug_out,
   input  logic                  debug_out_ready,
   input  dii_flit_t             debug_in,
   output logic                  debug_in_ready
);

   logic                  bus_req;
   uart_bus_req_t         bus;
   logic                  bus_ack;
   logic [REG_DATA_W-1:0] bus_rdata;

   logic                  tx_valid;
   logic [REG_DATA_W-1:0] tx_char;
   logic                  tx_ready;
   logic                  rx_valid;
   logic [REG_DATA_W-1:0] rx_char;
   logic                  rx_ready;

   uart_axi_bridge bridge_i (.*);

   uart_16550_regs regs_i (.*);

   uart_dii_emul emul_i (.*);

endmodule

/* uart_dii_emul.sv */
/* Character device on the debug interconnect. Sends each transmitted
   character as a four-flit event packet, unpacks incoming ones */

`timescale 1ns/1ps

module uart_dii_emul
   import dii_pkg::*;
(
   input  logic                clk,
   input  logic                rst,

   input  logic [DII_ID_W-1:0] id,

   input  logic                tx_valid,
   input  logic [7:0]          tx_char,
   output logic                tx_ready,

   output logic                rx_valid,
   output logic [7:0]          rx_char,
   input  logic                rx_ready,

   output dii_flit_t           debug_out,
   input  logic                debug_out_ready,

   input  dii_flit_t           debug_in,
   output logic                debug_in_ready
);

   logic                 tx_busy;
   logic [PKT_CNT_W-1:0] tx_cnt;
   logic [7:0]           tx_char_q;
   dii_word_u            out_word;

   logic                 rx_pend;
   logic                 rx_drop;
   logic [PKT_CNT_W-1:0] rx_cnt;
   logic [7:0]           rx_char_q;
   dii_word_u            in_word;
   logic                 in_take;

   assign tx_ready = !tx_busy;

   always_comb begin
      out_word = '0;
      case (tx_cnt)
         2'd0: out_word.raw = DII_DATA_W'(HOST_ID); // Destination
         2'd1: out_word.raw = DII_DATA_W'(id);
         HDR_FLIT: begin
            out_word.hdr.pkt_type = TYPE_EVENT;
            out_word.hdr.subtype  = SUBTYPE_CHAR;
         end
         default: out_word.chr.char = tx_char_q;
      endcase
   end

   assign debug_out = '{valid: tx_busy, last: tx_cnt == LAST_FLIT, data: out_word.raw};

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy <= 1'b0;
         tx_cnt  <= '0;
      end else if (!tx_busy) begin
         if (tx_valid) begin
            tx_busy <= 1'b1;
            tx_cnt  <= '0;
         end
      end else if (debug_out_ready) begin
         tx_cnt <= tx_cnt + 1'b1;
         if (tx_cnt == LAST_FLIT) tx_busy <= 1'b0;
      end
   end

   // Receive side, one pending character at most
   assign in_word        = debug_in.data;
   assign debug_in_ready = !rx_pend;
   assign in_take        = debug_in.valid && debug_in_ready;
   assign rx_valid       = rx_pend;
   assign rx_char        = rx_char_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_pend <= 1'b0;
         rx_drop <= 1'b0;
         rx_cnt  <= '0;
      end else begin
         if (rx_pend && rx_ready) rx_pend <= 1'b0;
         if (in_take) begin
            if (debug_in.last) begin
               rx_cnt  <= '0;
               rx_drop <= 1'b0;
               if (rx_cnt == LAST_FLIT && !rx_drop) rx_pend <= 1'b1;
            end else begin
               if (rx_cnt != LAST_FLIT) rx_cnt <= rx_cnt + 1'b1;
               else rx_drop <= 1'b1; // Overlong packet
               if (rx_cnt == HDR_FLIT && in_word.hdr.subtype != SUBTYPE_CHAR) begin
                  rx_drop <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_valid && tx_ready) tx_char_q <= tx_char;
      if (in_take && debug_in.last) rx_char_q <= in_word.chr.char;
   end

endmodule

/* uart_16550_regs.sv */
/* 16550 register file behind the four-phase register bus. Holds the
   one-character transmit holding register and receive buffer */

`timescale 1ns/1ps

module uart_16550_regs
   import uart_regs_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  bus_req,
   input  uart_bus_req_t         bus,
   output logic                  bus_ack,
   output logic [REG_DATA_W-1:0] bus_rdata,

   output logic                  tx_valid,
   output logic [REG_DATA_W-1:0] tx_char,
   input  logic                  tx_ready,

   input  logic                  rx_valid,
   input  logic [REG_DATA_W-1:0] rx_char,
   output logic                  rx_ready
);

   logic [REG_DATA_W-1:0] lcr;
   logic [REG_DATA_W-1:0] ier;
   logic [REG_DATA_W-1:0] scr;
   logic [REG_DATA_W-1:0] dll;
   logic [REG_DATA_W-1:0] dlm;
   logic [REG_DATA_W-1:0] thr;
   logic [REG_DATA_W-1:0] rbr;
   logic [REG_DATA_W-1:0] lsr;
   logic [REG_DATA_W-1:0] rd_val;
   logic                  thr_full;
   logic                  rx_full;
   logic                  dlab;
   logic                  thr_wr;
   logic                  rbr_rd;
   logic                  access;

   assign dlab   = lcr[LCR_DLAB];
   assign thr_wr = bus.write && bus.addr == REG_RBR_THR && !dlab;
   assign rbr_rd = !bus.write && bus.addr == REG_RBR_THR && !dlab;

   // THR write stalls until the holding register drains
   assign access = bus_req && !bus_ack && !(thr_wr && thr_full);

   assign tx_valid = thr_full;
   assign tx_char  = thr;
   assign rx_ready = !rx_full;

   always_comb begin
      lsr           = '0;
      lsr[LSR_DR]   = rx_full;
      lsr[LSR_THRE] = !thr_full;
      lsr[LSR_TEMT] = !thr_full;
   end

   always_comb begin
      case (bus.addr)
         REG_RBR_THR: rd_val = dlab ? dll : rbr;
         REG_IER:     rd_val = dlab ? dlm : ier;
         REG_IIR_FCR: rd_val = IIR_NO_INT;
         REG_LCR:     rd_val = lcr;
         REG_MCR:     rd_val = '0; // No modem control
         REG_LSR:     rd_val = lsr;
         REG_MSR:     rd_val = '0;
         REG_SCR:     rd_val = scr;
         default:     rd_val = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bus_ack  <= 1'b0;
         lcr      <= '0;
         ier      <= '0;
         scr      <= '0;
         dll      <= '0;
         dlm      <= '0;
         thr_full <= 1'b0;
         rx_full  <= 1'b0;
      end else begin
         if (access) begin
            bus_ack <= 1'b1;
         end else if (!bus_req) begin
            bus_ack <= 1'b0;
         end

         if (tx_valid && tx_ready) thr_full <= 1'b0;
         if (access && thr_wr) thr_full <= 1'b1;

         if (rx_valid && rx_ready) begin
            rx_full <= 1'b1; // A new char beats an empty read
         end else if (access && rbr_rd) begin
            rx_full <= 1'b0;
         end

         if (access && bus.write) begin
            case (bus.addr)
               REG_RBR_THR: if (dlab) dll <= bus.wdata;
               REG_IER: begin
                  if (dlab) dlm <= bus.wdata;
                  else      ier <= bus.wdata;
               end
               REG_LCR: lcr <= bus.wdata;
               REG_SCR: scr <= bus.wdata;
               default: ; // FCR, MCR ignored
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) bus_rdata <= rd_val;
      if (access && thr_wr) thr <= bus.wdata;
      if (rx_valid && rx_ready) rbr <= rx_char;
   end

endmodule

/* uart_axi_bridge.sv */
/* AXI-lite slave in front of the 16550 register block. Each read or
   write becomes one four-phase register access, writes win ties */

`timescale 1ns/1ps

module uart_axi_bridge
   import uart_regs_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic [REG_ADDR_W-1:0] ar_addr,
   input  logic                  ar_valid,
   output logic                  ar_ready,

   output logic [1:0]            r_resp,
   output logic [REG_DATA_W-1:0] r_data,
   output logic                  r_valid,
   input  logic                  r_ready,

   input  logic [REG_ADDR_W-1:0] aw_addr,
   input  logic                  aw_valid,
   output logic                  aw_ready,

   input  logic [REG_DATA_W-1:0] w_data,
   input  logic                  w_valid,
   output logic                  w_ready,

   output logic [1:0]            b_resp,
   output logic                  b_valid,
   input  logic                  b_ready,

   output logic                  bus_req,
   output uart_bus_req_t         bus,
   input  logic                  bus_ack,
   input  logic [REG_DATA_W-1:0] bus_rdata
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_RESP
   } state_t;

   state_t state;
   logic   wr_go;
   logic   rd_go;
   logic   resp_done;

   // Idle and previous ack gone
   assign wr_go = (state == ST_IDLE) && !bus_ack && aw_valid && w_valid;
   assign rd_go = (state == ST_IDLE) && !bus_ack && ar_valid && !(aw_valid && w_valid);

   assign aw_ready = wr_go;
   assign w_ready  = wr_go;
   assign ar_ready = rd_go;

   assign bus_req = (state == ST_REQ);

   assign r_valid = (state == ST_RESP) && !bus.write;
   assign b_valid = (state == ST_RESP) && bus.write;
   assign r_resp  = AXI_OKAY;
   assign b_resp  = AXI_OKAY;

   assign resp_done = (b_valid && b_ready) || (r_valid && r_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (wr_go || rd_go) state <= ST_REQ;
            ST_REQ:  if (bus_ack) state <= ST_RESP; // req drops here
            ST_RESP: if (resp_done) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request and read data
   always_ff @(posedge clk) begin
      if (wr_go) begin
         bus <= '{addr: aw_addr, write: 1'b1, wdata: w_data};
      end else if (rd_go) begin
         bus <= '{addr: ar_addr, write: 1'b0, wdata: '0};
      end
      if (state == ST_REQ && bus_ack) r_data <= bus_rdata;
   end

endmodule

/* dii_pkg.sv */
/* Debug interconnect flit format and the character packet layout
   used by the UART emulator and the debug host */

package dii_pkg;

   localparam int DII_DATA_W = 16;
   localparam int DII_ID_W   = 10;

   localparam logic [DII_ID_W-1:0] HOST_ID = 10'd0;

   // Character packet is dest, src, header, char
   localparam int PKT_LEN   = 4;
   localparam int PKT_CNT_W = $clog2(PKT_LEN);
   localparam logic [PKT_CNT_W-1:0] HDR_FLIT  = 2'd2;
   localparam logic [PKT_CNT_W-1:0] LAST_FLIT = 2'(PKT_LEN - 1);

   localparam logic [1:0] TYPE_EVENT   = 2'b10;
   localparam logic [3:0] SUBTYPE_CHAR = 4'h0;

   typedef struct packed {
      logic                  valid;
      logic                  last;
      logic [DII_DATA_W-1:0] data;
   } dii_flit_t;

   // Flit 2 reads as hdr, flit 3 as chr
   typedef union packed {
      logic [DII_DATA_W-1:0] raw;
      struct packed {
         logic [1:0] pkt_type;
         logic [3:0] subtype;
         logic [9:0] rsvd;
      } hdr;
      struct packed {
         logic [7:0] rsvd;
         logic [7:0] char;
      } chr;
   } dii_word_u;

endpackage

/* uart_regs_pkg.sv */
/* 16550 register map, bit positions and the register-bus request
   shared by the AXI-lite bridge and the register block */

package uart_regs_pkg;

   localparam int REG_ADDR_W = 3;
   localparam int REG_DATA_W = 8;

   // Register indices, DLAB selects DLL/DLM at 0 and 1
   localparam logic [REG_ADDR_W-1:0] REG_RBR_THR = 3'd0;
   localparam logic [REG_ADDR_W-1:0] REG_IER     = 3'd1;
   localparam logic [REG_ADDR_W-1:0] REG_IIR_FCR = 3'd2;
   localparam logic [REG_ADDR_W-1:0] REG_LCR     = 3'd3;
   localparam logic [REG_ADDR_W-1:0] REG_MCR     = 3'd4;
   localparam logic [REG_ADDR_W-1:0] REG_LSR     = 3'd5;
   localparam logic [REG_ADDR_W-1:0] REG_MSR     = 3'd6;
   localparam logic [REG_ADDR_W-1:0] REG_SCR     = 3'd7;

   localparam int LCR_DLAB = 7;

   // Line status bits
   localparam int LSR_DR   = 0;
   localparam int LSR_THRE = 5;
   localparam int LSR_TEMT = 6; // No shift register, tracks THRE

   localparam logic [REG_DATA_W-1:0] IIR_NO_INT = 8'h01;

   localparam logic [1:0] AXI_OKAY = 2'b00;

   // Held stable while req is high
   typedef struct packed {
      logic [REG_ADDR_W-1:0] addr;
      logic                  write;
      logic [REG_DATA_W-1:0] wdata;
   } uart_bus_req_t;

endpackage
